//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module clkcfg_tb -f sources.f

out=$(./obj_dir/Vclkcfg_tb)
echo "$out"

# Exit status follows the search
echo "$out" | grep -qx "ALL CHECKS PASSED"

//--- source/clkcfg_pkg.sv
`default_nettype none

package clkcfg_pkg;

        //////////////////////////////
        // Frame format of the AD9516 serial port

        localparam int SPI_ADDR_W  = 13;
        localparam int SPI_DATA_W  = 8;
        localparam int SPI_FRAME_W = 24;

        // Register table
        localparam int NUM_WRITES = 76;
        localparam int STEP_W     = 7;

        //////////////////////////////
        // Link and pin timing, in clk_in cycles

        localparam int SCLK_HALF   = 2;  // One SCLK period is 4 cycles
        localparam int CS_GAP      = 2;
        localparam int SPI_CREDITS = 2;
        localparam int DONE_LEN    = 2;

        // Sent MSB first, instruction word then data byte
        typedef struct packed {
                logic                  rw;   // 0 for write
                logic [1:0]            len;  // 00 is one byte
                logic [SPI_ADDR_W-1:0] addr;
                logic [SPI_DATA_W-1:0] data;
        } spi_frame_t;

        typedef enum logic [1:0] {
                SEQ_IDLE,
                SEQ_SEND,
                SEQ_DRAIN,
                SEQ_DONE
        } seq_state_e;

        typedef enum logic [1:0] {
                ENG_IDLE,
                ENG_SHIFT,
                ENG_GAP
        } eng_state_e;

endpackage

`default_nettype wire

//--- source/clkcfg_rom.sv
`timescale 1ns/1ns
`default_nettype none

module clkcfg_rom import clkcfg_pkg::*; (
        input  logic [STEP_W-1:0] i_step,
        output spi_frame_t        o_frame
);

        logic [SPI_ADDR_W-1:0] addr;
        logic [SPI_DATA_W-1:0] data;

        always_comb begin
                case (i_step)
                // Serial port and power-down setup
                7'd1:  {addr, data} = {13'h0001, 8'h00};
                7'd2:  {addr, data} = {13'h0002, 8'h10};
                7'd3:  {addr, data} = {13'h0003, 8'h43};
                7'd4:  {addr, data} = {13'h0004, 8'h00};
                //////////////////////////////
                // PLL dividers and charge pump
                7'd5:  {addr, data} = {13'h0010, 8'h7C};
                7'd6:  {addr, data} = {13'h0011, 8'h02};
                7'd7:  {addr, data} = {13'h0012, 8'h00};
                7'd8:  {addr, data} = {13'h0013, 8'h00};
                7'd9:  {addr, data} = {13'h0014, 8'h05};
                7'd10: {addr, data} = {13'h0015, 8'h00};
                7'd11: {addr, data} = {13'h0016, 8'h04};
                7'd12: {addr, data} = {13'h0017, 8'hAC};
                7'd13: {addr, data} = {13'h0018, 8'h07};  // VCO cal divider
                7'd14: {addr, data} = {13'h0019, 8'h40};
                7'd15: {addr, data} = {13'h001A, 8'h00};
                7'd16: {addr, data} = {13'h001B, 8'h01};
                7'd17: {addr, data} = {13'h001C, 8'h07};
                7'd18: {addr, data} = {13'h001D, 8'h0A};
                7'd19: {addr, data} = {13'h001E, 8'h00};
                7'd20: {addr, data} = {13'h001F, 8'h0E};
                // Fine delay blocks
                7'd21: {addr, data} = {13'h00A0, 8'h01};
                7'd22: {addr, data} = {13'h00A1, 8'h00};
                7'd23: {addr, data} = {13'h00A2, 8'h00};
                7'd24: {addr, data} = {13'h00A3, 8'h01};
                7'd25: {addr, data} = {13'h00A4, 8'h00};
                7'd26: {addr, data} = {13'h00A5, 8'h00};
                7'd27: {addr, data} = {13'h00A6, 8'h01};
                7'd28: {addr, data} = {13'h00A7, 8'h00};
                7'd29: {addr, data} = {13'h00A8, 8'h00};
                7'd30: {addr, data} = {13'h00A9, 8'h01};
                7'd31: {addr, data} = {13'h00AA, 8'h00};
                7'd32: {addr, data} = {13'h00AB, 8'h00};
                //////////////////////////////
                // LVPECL and LVDS/CMOS outputs
                7'd33: {addr, data} = {13'h00F0, 8'h0A};
                7'd34: {addr, data} = {13'h00F1, 8'h0A};
                7'd35: {addr, data} = {13'h00F2, 8'h0A};
                7'd36: {addr, data} = {13'h00F3, 8'h0A};
                7'd37: {addr, data} = {13'h00F4, 8'h0A};
                7'd38: {addr, data} = {13'h00F5, 8'h08};
                7'd39: {addr, data} = {13'h0140, 8'h42};
                7'd40: {addr, data} = {13'h0141, 8'h43};
                7'd41: {addr, data} = {13'h0142, 8'h42};
                7'd42: {addr, data} = {13'h0143, 8'h42};
                // Output channel dividers
                7'd43: {addr, data} = {13'h0190, 8'h00};
                7'd44: {addr, data} = {13'h0191, 8'h80};
                7'd45: {addr, data} = {13'h0192, 8'h00};
                7'd46: {addr, data} = {13'h0193, 8'hBB};
                7'd47: {addr, data} = {13'h0194, 8'h00};
                7'd48: {addr, data} = {13'h0195, 8'h00};
                7'd49: {addr, data} = {13'h0196, 8'h11};
                7'd50: {addr, data} = {13'h0197, 8'h80};
                7'd51: {addr, data} = {13'h0198, 8'h00};
                7'd52: {addr, data} = {13'h0199, 8'h11};
                7'd53: {addr, data} = {13'h019A, 8'h00};
                7'd54: {addr, data} = {13'h019B, 8'h00};
                7'd55: {addr, data} = {13'h019C, 8'h00};
                7'd56: {addr, data} = {13'h019D, 8'h00};
                7'd57: {addr, data} = {13'h019E, 8'h11};
                7'd58: {addr, data} = {13'h019F, 8'h00};
                7'd59: {addr, data} = {13'h01A0, 8'h00};
                7'd60: {addr, data} = {13'h01A1, 8'h00};
                7'd61: {addr, data} = {13'h01A2, 8'h00};
                7'd62: {addr, data} = {13'h01A3, 8'h00};
                // VCO divider, input select, sync and update
                7'd63: {addr, data} = {13'h01E0, 8'h00};
                7'd64: {addr, data} = {13'h01E1, 8'h02};
                7'd65: {addr, data} = {13'h0230, 8'h00};
                7'd66: {addr, data} = {13'h0231, 8'h00};
                7'd67: {addr, data} = {13'h0232, 8'h00};
                //////////////////////////////
                // Calibration toggle, then soft sync
                7'd68: {addr, data} = {13'h0018, 8'h06};
                7'd69: {addr, data} = {13'h0232, 8'h01};
                7'd70: {addr, data} = {13'h0018, 8'h07};  // Starts VCO cal
                7'd71: {addr, data} = {13'h0232, 8'h01};
                7'd72: {addr, data} = {13'h0230, 8'h01};
                7'd73: {addr, data} = {13'h0232, 8'h01};
                7'd74: {addr, data} = {13'h0230, 8'h00};  // Release sync
                7'd75: {addr, data} = {13'h0232, 8'h01};
                // Step 0, also anything past the table
                default: {addr, data} = {13'h0000, 8'h18};
                endcase
        end

        // Write, one byte
        assign o_frame = '{rw: 1'b0, len: 2'b00, addr: addr, data: data};

endmodule

`default_nettype wire

//--- source/clkcfg_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module clkcfg_sequencer import clkcfg_pkg::*; (
        input  logic              clk_in,
        input  logic              rst_n,
        input  logic              i_start,
        output logic              o_ready,
        output logic              o_cfg_done,
        output logic [STEP_W-1:0] o_step,
        input  spi_frame_t        i_frame,
        output spi_frame_t        o_frame,
        output logic              o_send,
        input  logic              i_credit_ret
);

        seq_state_e        state;
        logic [STEP_W-1:0] step;
        logic [1:0]        credits;
        logic [1:0]        credits_nxt;
        logic [1:0]        done_cnt;
        logic              send_fire;

        assign send_fire   = (state == SEQ_SEND) && (credits != 2'd0);
        assign credits_nxt = credits + {1'b0, i_credit_ret} - {1'b0, send_fire};

        assign o_step     = step;
        assign o_ready    = (state == SEQ_IDLE);
        assign o_cfg_done = (state == SEQ_DONE);

        // Frame goes out with its strobe
        always_ff @(posedge clk_in) begin
                if (send_fire) begin
                        o_frame <= i_frame;
                end
        end

        always_ff @(posedge clk_in) begin
                if (!rst_n) begin
                        state    <= SEQ_IDLE;
                        step     <= '0;
                        credits  <= 2'(SPI_CREDITS);
                        done_cnt <= '0;
                        o_send   <= 1'b0;
                end else begin
                        o_send  <= send_fire;
                        credits <= credits_nxt;
                        case (state)
                        SEQ_IDLE: begin
                                if (i_start) begin
                                        step  <= '0;
                                        state <= SEQ_SEND;
                                end
                        end
                        SEQ_SEND: begin
                                if (send_fire) begin
                                        if (step == STEP_W'(NUM_WRITES - 1)) begin
                                                state <= SEQ_DRAIN;
                                        end else begin
                                                step <= step + STEP_W'(1);
                                        end
                                end
                        end
                        SEQ_DRAIN: begin
                                // Last frame has left the pins
                                if (credits_nxt == 2'(SPI_CREDITS)) begin
                                        done_cnt <= '0;
                                        state    <= SEQ_DONE;
                                end
                        end
                        default: begin
                                if (done_cnt == 2'(DONE_LEN - 1)) begin
                                        state <= SEQ_IDLE;
                                end else begin
                                        done_cnt <= done_cnt + 2'd1;
                                end
                        end
                        endcase
                end
        end

        //////////////////////////////
        // Credit link checks

        // A frame on the link always holds one credit
        a_send_needs_credit: assert property (@(posedge clk_in) disable iff (!rst_n)
                o_send |-> credits != 2'(SPI_CREDITS))
                else $error("send issued without spending a credit");

        a_credit_bound: assert property (@(posedge clk_in) disable iff (!rst_n)
                credits <= 2'(SPI_CREDITS))
                else $error("engine returned more credits than it was given");

endmodule

`default_nettype wire

//--- source/clkcfg_top.sv
`timescale 1ns/1ns
`default_nettype none

module clkcfg_top import clkcfg_pkg::*; (
        input  logic clk_in,
        input  logic rst_n,
        input  logic i_start,
        output logic o_ready,
        output logic o_cfg_done,
        output logic o_sclk,
        output logic o_sda,
        output logic o_cs_n
);

        logic [STEP_W-1:0] step;
        spi_frame_t        rom_frame;
        spi_frame_t        seq_frame;
        logic              send;
        logic              credit_ret;

        clkcfg_sequencer seq0 (
                .clk_in       (clk_in),
                .rst_n        (rst_n),
                .i_start      (i_start),
                .o_ready      (o_ready),
                .o_cfg_done   (o_cfg_done),
                .o_step       (step),
                .i_frame      (rom_frame),
                .o_frame      (seq_frame),
                .o_send       (send),
                .i_credit_ret (credit_ret)
        );

        clkcfg_rom rom0 (
                .i_step  (step),
                .o_frame (rom_frame)
        );

        spi_write_engine eng0 (
                .clk_in       (clk_in),
                .rst_n        (rst_n),
                .i_frame      (seq_frame),
                .i_send       (send),
                .o_credit_ret (credit_ret),
                .o_sclk       (o_sclk),
                .o_sda        (o_sda),
                .o_cs_n       (o_cs_n)
        );

endmodule

`default_nettype wire

//--- source/spi_write_engine.sv
`timescale 1ns/1ns
`default_nettype none

module spi_write_engine import clkcfg_pkg::*; (
        input  logic       clk_in,
        input  logic       rst_n,
        input  spi_frame_t i_frame,
        input  logic       i_send,
        output logic       o_credit_ret,
        output logic       o_sclk,
        output logic       o_sda,
        output logic       o_cs_n
);

        eng_state_e state;

        // Frame slots, one per credit
        spi_frame_t slot [SPI_CREDITS];
        logic       wr_ptr;
        logic       rd_ptr;
        logic [1:0] count;

        logic [1:0]             phase_cnt;
        logic [4:0]             bit_cnt;
        logic [1:0]             gap_cnt;
        logic [SPI_FRAME_W-1:0] shreg;
        logic                   phase_end;
        logic                   last_bit;
        logic                   load;

        assign phase_end = (phase_cnt == 2'(SCLK_HALF - 1));
        assign last_bit  = (bit_cnt == 5'(SPI_FRAME_W - 1));

        // Start from idle, or straight out of a finished gap
        assign load = (count != 2'd0) &&
                      ((state == ENG_IDLE) ||
                       ((state == ENG_GAP) && (gap_cnt == 2'(CS_GAP - 1))));

        assign o_sda = shreg[SPI_FRAME_W-1];

        //////////////////////////////
        // Frame buffer

        always_ff @(posedge clk_in) begin
                if (i_send) begin
                        slot[wr_ptr] <= i_frame;
                end
        end

        always_ff @(posedge clk_in) begin
                if (!rst_n) begin
                        wr_ptr <= 1'b0;
                        rd_ptr <= 1'b0;
                        count  <= 2'd0;
                end else begin
                        if (i_send) begin
                                wr_ptr <= ~wr_ptr;
                        end
                        if (load) begin
                                rd_ptr <= ~rd_ptr;
                        end
                        count <= count + {1'b0, i_send} - {1'b0, load};
                end
        end

        //////////////////////////////
        // Shifter and CS_n framing

        always_ff @(posedge clk_in) begin
                if (!rst_n) begin
                        state        <= ENG_IDLE;
                        o_cs_n       <= 1'b1;
                        o_sclk       <= 1'b0;
                        o_credit_ret <= 1'b0;
                        shreg        <= '0;
                        phase_cnt    <= '0;
                        bit_cnt      <= '0;
                        gap_cnt      <= '0;
                end else begin
                        o_credit_ret <= 1'b0;
                        if (load) begin
                                shreg     <= slot[rd_ptr];  // MSB on SDA with CS_n fall
                                o_cs_n    <= 1'b0;
                                o_sclk    <= 1'b0;
                                phase_cnt <= '0;
                                bit_cnt   <= '0;
                                state     <= ENG_SHIFT;
                        end else begin
                                case (state)
                                ENG_SHIFT: begin
                                        phase_cnt <= phase_end ? 2'd0 : phase_cnt + 2'd1;
                                        if (phase_end && !o_sclk) begin
                                                o_sclk <= 1'b1;
                                        end else if (phase_end && last_bit) begin
                                                o_sclk       <= 1'b0;
                                                o_cs_n       <= 1'b1;
                                                o_credit_ret <= 1'b1;  // Slot freed
                                                gap_cnt      <= '0;
                                                state        <= ENG_GAP;
                                        end else if (phase_end) begin
                                                // Falling edge moves SDA on
                                                o_sclk  <= 1'b0;
                                                shreg   <= shreg << 1;
                                                bit_cnt <= bit_cnt + 5'd1;
                                        end
                                end
                                ENG_GAP: begin
                                        if (gap_cnt == 2'(CS_GAP - 1)) begin
                                                state <= ENG_IDLE;
                                        end else begin
                                                gap_cnt <= gap_cnt + 2'd1;
                                        end
                                end
                                default: ;
                                endcase
                        end
                end
        end

        a_sclk_idle_low: assert property (@(posedge clk_in) disable iff (!rst_n)
                o_cs_n |-> !o_sclk)
                else $error("SCLK high outside a frame");

        a_no_overflow: assert property (@(posedge clk_in) disable iff (!rst_n)
                i_send |-> count != 2'(SPI_CREDITS))
                else $error("frame sent with both slots full");

endmodule

`default_nettype wire

//--- sources.f
source/clkcfg_pkg.sv
source/clkcfg_rom.sv
source/clkcfg_sequencer.sv
source/spi_write_engine.sv
source/clkcfg_top.sv
tests/spi_frame_monitor.sv
tests/clkcfg_tb.sv

//--- tests/clkcfg_tb.sv
`timescale 1ns/1ns
`default_nettype none

module clkcfg_tb import clkcfg_pkg::*; ();

        localparam int FRAME_CYC = 98;
        localparam int RUN_LIMIT = NUM_WRITES * FRAME_CYC + 200;
        localparam int NUM_RUNS  = 5;
        localparam int WATCH_NS  = (NUM_RUNS * NUM_WRITES * FRAME_CYC + 5000) * 4;

        // Expected frames, write bit and length zero, then address and data
        localparam logic [23:0] EXP_WORDS [NUM_WRITES] = '{
                24'h000018, 24'h000100, 24'h000210, 24'h000343, 24'h000400, 24'h00107C,
                24'h001102, 24'h001200, 24'h001300, 24'h001405, 24'h001500, 24'h001604,
                24'h0017AC, 24'h001807, 24'h001940, 24'h001A00, 24'h001B01, 24'h001C07,
                24'h001D0A, 24'h001E00, 24'h001F0E, 24'h00A001, 24'h00A100, 24'h00A200,
                24'h00A301, 24'h00A400, 24'h00A500, 24'h00A601, 24'h00A700, 24'h00A800,
                24'h00A901, 24'h00AA00, 24'h00AB00, 24'h00F00A, 24'h00F10A, 24'h00F20A,
                24'h00F30A, 24'h00F40A, 24'h00F508, 24'h014042, 24'h014143, 24'h014242,
                24'h014342, 24'h019000, 24'h019180, 24'h019200, 24'h0193BB, 24'h019400,
                24'h019500, 24'h019611, 24'h019780, 24'h019800, 24'h019911, 24'h019A00,
                24'h019B00, 24'h019C00, 24'h019D00, 24'h019E11, 24'h019F00, 24'h01A000,
                24'h01A100, 24'h01A200, 24'h01A300, 24'h01E000, 24'h01E102, 24'h023000,
                24'h023100, 24'h023200, 24'h001806, 24'h023201, 24'h001807, 24'h023201,
                24'h023001, 24'h023201, 24'h023000, 24'h023201
        };

        logic clk_in;
        logic rst_n;
        logic i_start;
        logic o_ready;
        logic o_cfg_done;
        logic o_sclk;
        logic o_sda;
        logic o_cs_n;

        int          errors;
        int          checks;
        int          done_rises;
        logic [15:0] lfsr;

        clkcfg_top dut0 (
                .clk_in     (clk_in),
                .rst_n      (rst_n),
                .i_start    (i_start),
                .o_ready    (o_ready),
                .o_cfg_done (o_cfg_done),
                .o_sclk     (o_sclk),
                .o_sda      (o_sda),
                .o_cs_n     (o_cs_n)
        );

        spi_frame_monitor mon0 (
                .clk_in (clk_in),
                .i_sclk (o_sclk),
                .i_sda  (o_sda),
                .i_cs_n (o_cs_n)
        );

        initial begin
                clk_in = 1'b0;
                forever #2 clk_in = ~clk_in;
        end

        initial done_rises = 0;
        always @(posedge o_cfg_done) done_rises++;

        initial begin
                #(WATCH_NS);
                $display("watchdog expired before the tests finished");
                $display("CHECKS FAILED");
                $finish;
        end

        //////////////////////////////
        // Check helpers

        task automatic expect_eq(input string name, input string what, input int exp,
                                 input int act);
                checks++;
                assert (exp == act) else begin
                        $display("mismatch %s %s: expected %0h actual %0h",
                                 name, what, exp, act);
                        errors++;
                end
        endtask

        task automatic expect_true(input string name, input logic cond, input string msg);
                checks++;
                assert (cond) else begin
                        $display("%s: %s", name, msg);
                        errors++;
                end
        endtask

        // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
        function automatic int rand_bits(input int n);
                int val;
                val = 0;
                for (int i = 0; i < n; i++) begin
                        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
                        val  = {val[30:0], lfsr[0]};
                end
                return val;
        endfunction

        task automatic check_idle_pins(input string name);
                expect_eq(name, "o_cs_n", 1, int'(o_cs_n));
                expect_eq(name, "o_sclk", 0, int'(o_sclk));
                expect_eq(name, "o_cfg_done", 0, int'(o_cfg_done));
                expect_eq(name, "o_ready", 1, int'(o_ready));
        endtask

        //////////////////////////////
        // Tests

        task automatic test_reset();
                rst_n = 1'b0;
                repeat (4) begin
                        @(negedge clk_in);
                        check_idle_pins("reset");
                        expect_eq("reset", "o_sda", 0, int'(o_sda));
                end
                rst_n = 1'b1;
                @(negedge clk_in);
                check_idle_pins("reset");
        endtask

        // One full run, optionally with stray start pulses while busy
        task automatic run_config(input string name, input logic noisy);
                int base_w;
                int base_g;
                int base_d;
                int cycles;
                int since;
                int len;
                int r;
                int n;
                base_w = mon0.words.size();
                base_d = done_rises;
                cycles = 0;
                since  = 0;
                @(negedge clk_in);
                expect_eq(name, "o_ready before start", 1, int'(o_ready));
                i_start = 1'b1;
                @(negedge clk_in);
                i_start = 1'b0;
                while (!o_cfg_done && cycles < RUN_LIMIT) begin
                        if (noisy) begin
                                r       = rand_bits(3);
                                i_start = (r == 0 && !o_ready) ? 1'b1 : 1'b0;
                        end
                        @(negedge clk_in);
                        cycles++;
                        since = o_cs_n ? since + 1 : 0;
                end
                i_start = 1'b0;
                expect_true(name, cycles < RUN_LIMIT, "no done pulse within the run limit");
                if (cycles >= RUN_LIMIT) return;
                expect_eq(name, "cycles from CS_n rise to done", 2, since);
                len = 0;
                while (o_cfg_done && len < 10) begin
                        len++;
                        @(negedge clk_in);
                end
                expect_eq(name, "done length", DONE_LEN, len);
                expect_eq(name, "o_ready after done", 1, int'(o_ready));
                repeat (20) @(negedge clk_in);
                expect_eq(name, "done pulses", base_d + 1, done_rises);
                n = mon0.words.size() - base_w;
                expect_eq(name, "frame count", NUM_WRITES, n);
                if (n != NUM_WRITES) return;
                for (int i = 0; i < NUM_WRITES; i++) begin
                        expect_eq(name, "frame", int'(EXP_WORDS[i]),
                                  int'(mon0.words[base_w + i]));
                        expect_eq(name, "top bits", 0, int'(mon0.words[base_w + i][23:21]));
                        expect_eq(name, "bits", SPI_FRAME_W, mon0.bit_counts[base_w + i]);
                        expect_eq(name, "CS_n low cycles", 96, mon0.low_lens[base_w + i]);
                end
                // Gaps inside the run are the last ones pushed
                base_g = mon0.gap_lens.size() - (NUM_WRITES - 1);
                for (int i = 0; i < NUM_WRITES - 1; i++) begin
                        expect_eq(name, "CS_n gap", CS_GAP, mon0.gap_lens[base_g + i]);
                end
                expect_eq(name, "SCLK high with CS_n high", 0, mon0.sclk_faults);
        endtask

        task automatic test_mid_reset();
                int wait_cyc;
                int base_d;
                base_d = done_rises;
                @(negedge clk_in);
                i_start = 1'b1;
                @(negedge clk_in);
                i_start = 1'b0;
                wait_cyc = rand_bits(9);
                repeat (300 + wait_cyc) @(negedge clk_in);
                rst_n = 1'b0;
                repeat (4) @(negedge clk_in);
                expect_eq("mid_reset", "o_cs_n in reset", 1, int'(o_cs_n));
                rst_n = 1'b1;
                @(negedge clk_in);
                check_idle_pins("mid_reset");
                // Past the point where the aborted run would have ended
                repeat (RUN_LIMIT) @(negedge clk_in);
                expect_eq("mid_reset", "done pulses", base_d, done_rises);
                run_config("mid_reset_rerun", 1'b0);
        endtask

        initial begin
                errors  = 0;
                checks  = 0;
                lfsr    = 16'd20;
                rst_n   = 1'b0;
                i_start = 1'b0;
                test_reset();
                run_config("full_config", 1'b0);
                run_config("start_while_busy", 1'b1);
                run_config("second_run", 1'b0);
                test_mid_reset();
                $display("errors: %0d of %0d checks", errors, checks);
                if (errors == 0) begin
                        $display("ALL CHECKS PASSED");
                end else begin
                        $display("CHECKS FAILED");
                end
                $finish;
        end

endmodule

`default_nettype wire

//--- tests/spi_frame_monitor.sv
`timescale 1ns/1ns
`default_nettype none

module spi_frame_monitor (
        input  logic clk_in,
        input  logic i_sclk,
        input  logic i_sda,
        input  logic i_cs_n
);

        // Collected per frame, read by the testbench
        logic [23:0] words [$];
        int          bit_counts [$];
        int          low_lens [$];
        int          gap_lens [$];
        int          sclk_faults;

        logic [23:0] shift;
        int          nbits;
        int          low_cnt;
        int          high_cnt;
        logic        cs_q;
        logic        sclk_q;
        logic        seen_rise;

        initial begin
                shift       = '0;
                nbits       = 0;
                low_cnt     = 0;
                high_cnt    = 0;
                cs_q        = 1'b1;
                sclk_q      = 1'b0;
                seen_rise   = 1'b0;
                sclk_faults = 0;
        end

        // Pins are steady at the falling clock edge
        always @(negedge clk_in) begin
                if (!i_cs_n) begin
                        if (cs_q) begin
                                if (seen_rise) gap_lens.push_back(high_cnt);
                                low_cnt = 0;
                                nbits   = 0;
                                shift   = '0;
                        end
                        low_cnt++;
                        if (i_sclk && !sclk_q) begin  // SCLK rose in this cycle
                                shift = {shift[22:0], i_sda};
                                nbits++;
                        end
                end else begin
                        if (!cs_q) begin
                                words.push_back(shift);
                                bit_counts.push_back(nbits);
                                low_lens.push_back(low_cnt);
                                seen_rise = 1'b1;
                                high_cnt  = 0;
                        end
                        high_cnt++;
                        if (i_sclk) sclk_faults++;
                end
                cs_q   = i_cs_n;
                sclk_q = i_sclk;
        end

endmodule

`default_nettype wire
